/* vlog.f */
rtl/lsu_pkg.sv
rtl/dcache_if.sv
rtl/memctrl_if.sv
rtl/lsu_stage.sv
rtl/dcache.sv
rtl/byte_mem_port.sv
rtl/mem_subsys_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_top -f vlog.f -o tb_sim || exit 1

out=$(./obj_dir/tb_sim)
echo "$out"

echo "$out" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1

/* testbench/tb_top.sv */
module tb_top import lsu_pkg::*; ();

	typedef struct {
		logic [OP_W-1:0]   op;
		logic [ADDR_W-1:0] addr;
		logic              hit;   // expected stall length is the hit length
		logic              frz;   // pulse stall_i for 3 cycles mid-op
		logic              nm;    // non-memory row
	} row_t;

	logic                  clk = 1'b0;
	logic                  rst_i;
	logic [OP_W-1:0]       opcode_i;
	logic [ADDR_W-1:0]     addr_i;
	logic [XLEN-1:0]       wdata_i;
	logic [REG_ADDR_W-1:0] wd_i;
	logic                  wreg_i;
	logic                  stall_i;
	logic [REG_ADDR_W-1:0] wd_o;
	logic                  wreg_o;
	logic [XLEN-1:0]       wdata_o;
	logic                  stall_req_o;
	logic                  row_nm;
	logic                  exp_hit;
	logic                  run_done;
	int                    row_id;
	bit                    timed_out;
	row_t                  rows[$];

	always #4 clk = ~clk;

	mem_subsys_top DUT (
		.clk(clk), .rst_i(rst_i), .opcode_i(opcode_i), .addr_i(addr_i),
		.wdata_i(wdata_i), .wd_i(wd_i), .wreg_i(wreg_i), .stall_i(stall_i),
		.wd_o(wd_o), .wreg_o(wreg_o), .wdata_o(wdata_o), .stall_req_o(stall_req_o)
	);

	tb_checker chk (
		.clk(clk), .rst_i(rst_i), .opcode_i(opcode_i), .addr_i(addr_i),
		.wdata_i(wdata_i), .wd_i(wd_i), .wreg_i(wreg_i), .stall_i(stall_i),
		.wd_o(wd_o), .wreg_o(wreg_o), .wdata_o(wdata_o), .stall_req_o(stall_req_o),
		.row_nm_i(row_nm), .exp_hit_i(exp_hit), .row_id_i(row_id), .run_done_i(run_done)
	);

	task automatic add_row(input logic [2:0] f3, input logic [6:0] opc,
		input logic [ADDR_W-1:0] a, input logic h, input logic f);
		row_t r;
		r.op   = {f3, opc};
		r.addr = a;
		r.hit  = h;
		r.frz  = f;
		r.nm   = (opc != OPC_LOAD) && (opc != OPC_STORE);
		rows.push_back(r);
	endtask

	task automatic drive_bubble();
		opcode_i = '0;
		wreg_i   = 1'b0;
		row_nm   = 1'b0;
	endtask

	// bounded wait for stall_req_o to fall after an edge
	task automatic wait_fall(output bit ok);
		ok = 1'b0;
		for (int n = 0; n < 20; n++) begin
			@(posedge clk);
			#1;
			if (!stall_req_o) begin
				ok = 1'b1;
				break;
			end
		end
	endtask

	task automatic apply_row(input int i);
		logic [31:0] r;
		bit          ok;
		r        = $urandom();
		row_id   = i;
		opcode_i = rows[i].op;
		addr_i   = rows[i].addr;
		wdata_i  = $urandom();
		wd_i     = r[4:0];
		wreg_i   = r[5];
		row_nm   = rows[i].nm;
		exp_hit  = rows[i].hit;
		if (rows[i].frz) begin
			repeat (2) @(posedge clk);   // first byte already in flight
			#1 stall_i = 1'b1;
			repeat (3) @(posedge clk);
			#1 stall_i = 1'b0;
		end
		wait_fall(ok);
		if (!ok) begin
			$display("timeout: stall_req_o never dropped on row %0d", i);
			timed_out = 1'b1;
		end
		drive_bubble();   // one idle cycle lets the done flag clear
		@(posedge clk);
		#1;
	endtask

	initial begin
		rst_i    = 1'b1;
		opcode_i = '0;
		addr_i   = '0;
		wdata_i  = '0;
		wd_i     = '0;
		wreg_i   = 1'b1;
		stall_i  = 1'b0;
		row_nm   = 1'b0;
		exp_hit  = 1'b0;
		run_done = 1'b0;
		row_id   = 0;
		void'($urandom(6787));

		// stores then loads of the covered lanes
		add_row(F3_SW, OPC_STORE, 32'h100, 0, 0);
		add_row(F3_LW, OPC_LOAD, 32'h100, 1, 0);
		add_row(F3_LH, OPC_LOAD, 32'h102, 1, 0);
		add_row(F3_LHU, OPC_LOAD, 32'h100, 1, 0);
		add_row(F3_LB, OPC_LOAD, 32'h103, 1, 0);
		add_row(F3_LBU, OPC_LOAD, 32'h101, 1, 0);
		add_row(F3_SH, OPC_STORE, 32'h20a, 0, 0);
		add_row(F3_LH, OPC_LOAD, 32'h20a, 1, 0);
		add_row(F3_LHU, OPC_LOAD, 32'h20a, 1, 0);
		add_row(F3_LB, OPC_LOAD, 32'h20b, 1, 0);
		add_row(F3_LBU, OPC_LOAD, 32'h20a, 1, 0);
		add_row(F3_SB, OPC_STORE, 32'h045, 0, 0);
		add_row(F3_LB, OPC_LOAD, 32'h045, 1, 0);
		add_row(F3_LBU, OPC_LOAD, 32'h045, 1, 0);
		add_row(3'b000, 7'b0110011, 32'h0, 0, 0);
		// index 0 shared by 0x100, 0x180 and 0x300
		add_row(F3_SW, OPC_STORE, 32'h180, 0, 0);
		add_row(F3_LW, OPC_LOAD, 32'h100, 0, 0);
		add_row(F3_LW, OPC_LOAD, 32'h100, 1, 0);
		add_row(F3_LH, OPC_LOAD, 32'h182, 0, 0);
		add_row(F3_LHU, OPC_LOAD, 32'h182, 1, 0);
		add_row(F3_LB, OPC_LOAD, 32'h181, 0, 0);
		add_row(F3_LBU, OPC_LOAD, 32'h181, 1, 0);
		add_row(F3_SW, OPC_STORE, 32'h300, 0, 0);
		add_row(F3_LBU, OPC_LOAD, 32'h183, 0, 0);
		add_row(F3_LHU, OPC_LOAD, 32'h100, 0, 0);
		add_row(F3_LB, OPC_LOAD, 32'h100, 1, 0);
		add_row(3'b000, 7'b0010011, 32'h0, 0, 0);
		// frozen cycles in an LW miss and an SW
		add_row(F3_SW, OPC_STORE, 32'h104, 0, 0);
		add_row(F3_SW, OPC_STORE, 32'h184, 0, 0);
		add_row(F3_LW, OPC_LOAD, 32'h104, 0, 1);
		add_row(F3_SW, OPC_STORE, 32'h108, 0, 1);
		add_row(F3_LW, OPC_LOAD, 32'h108, 1, 0);
		// 0x188 evicts 0x108 so its bytes come back from the RAM
		add_row(F3_SW, OPC_STORE, 32'h188, 0, 0);
		add_row(F3_LW, OPC_LOAD, 32'h108, 0, 0);
		add_row(3'b000, 7'b0110011, 32'h0, 0, 0);

		repeat (16) @(posedge clk);
		#1 rst_i = 1'b0;
		wreg_i = 1'b0;
		repeat (3) @(posedge clk);   // idle outputs checked meanwhile
		#1;
		for (int i = 0; i < rows.size(); i++) begin
			if (!timed_out) begin
				apply_row(i);
			end
		end
		repeat (2) @(posedge clk);
		run_done = 1'b1;
		#1;
		if (timed_out || chk.fail_cnt != 0 || chk.pass_cnt != rows.size()) begin
			$display("*** TEST FAILED ***");
		end else begin
			$display("*** TEST PASSED ***");
		end
		$finish;
	end

endmodule

/* testbench/tb_checker.sv */
module tb_checker import lsu_pkg::*; (
	input logic                  clk,
	input logic                  rst_i,
	input logic [OP_W-1:0]       opcode_i,
	input logic [ADDR_W-1:0]     addr_i,
	input logic [XLEN-1:0]       wdata_i,
	input logic [REG_ADDR_W-1:0] wd_i,
	input logic                  wreg_i,
	input logic                  stall_i,
	input logic [REG_ADDR_W-1:0] wd_o,
	input logic                  wreg_o,
	input logic [XLEN-1:0]       wdata_o,
	input logic                  stall_req_o,
	input logic                  row_nm_i,
	input logic                  exp_hit_i,
	input int                    row_id_i,
	input logic                  run_done_i
);

	logic [7:0]       ram_m [2**MEM_AW];
	logic [TAG_W-1:0] tag_m [CACHE_LINES];
	logic [3:0]       val_m [CACHE_LINES];
	int               pass_cnt = 0;
	int               fail_cnt = 0;
	bit               active = 0;
	bit               seen_row = 0;
	int               edges;
	int               frozen;
	logic [OP_W-1:0]  op_l;
	logic [ADDR_W-1:0] addr_l;
	logic [XLEN-1:0]  data_l;
	logic             flag_l;
	logic             mhit_l;
	int               id_l;
	logic             nm_prev = 0;
	logic [XLEN-1:0]  prev_wdata;
	logic [REG_ADDR_W-1:0] prev_wd;
	logic             prev_wreg;

	initial begin
		for (int i = 0; i < CACHE_LINES; i++) begin
			val_m[i] = '0;
			tag_m[i] = '0;
		end
	end

	function automatic bit mem_op(input logic [OP_W-1:0] op);
		return op[6:0] == OPC_LOAD || op[6:0] == OPC_STORE;
	endfunction

	function automatic int nbytes(input logic [OP_W-1:0] op);
		return (op[8:7] == 2'b00) ? 1 : (op[8:7] == 2'b01) ? 2 : 4;
	endfunction

	function automatic logic [3:0] lanes(input logic [ADDR_W-1:0] a, input int n);
		logic [3:0] m;
		m = '0;
		for (int k = 0; k < n; k++) begin
			m[a[1:0] + 2'(k)] = 1'b1;
		end
		return m;
	endfunction

	function automatic bit model_hit(input logic [ADDR_W-1:0] a, input int n);
		logic [CACHE_IW-1:0] idx;
		idx = a[CACHE_IW+1:2];
		return tag_m[idx] == a[ADDR_W-1:CACHE_IW+2] && (val_m[idx] & lanes(a, n)) == lanes(a, n);
	endfunction

	// expected result from the RAM model, extended as funct3 asks
	function automatic logic [XLEN-1:0] expect_load(input logic [ADDR_W-1:0] a,
		input logic [2:0] f3);
		logic [XLEN-1:0]   raw;
		logic [MEM_AW-1:0] ra;
		int                n;
		raw = '0;
		n   = (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
		for (int k = 0; k < n; k++) begin
			ra           = a[MEM_AW-1:0] + MEM_AW'(k);
			raw[8*k +: 8] = ram_m[ra];
		end
		if (!f3[2] && n == 1 && raw[7]) raw[31:8] = '1;
		if (!f3[2] && n == 2 && raw[15]) raw[31:16] = '1;
		return raw;
	endfunction

	task automatic cache_update(input logic [ADDR_W-1:0] a, input int n);
		logic [CACHE_IW-1:0] idx;
		idx = a[CACHE_IW+1:2];
		if (tag_m[idx] == a[ADDR_W-1:CACHE_IW+2]) begin
			val_m[idx] = val_m[idx] | lanes(a, n);
		end else begin
			tag_m[idx] = a[ADDR_W-1:CACHE_IW+2];
			val_m[idx] = lanes(a, n);
		end
	endtask

	task automatic finish_op();
		int              n;
		int              exp_len;
		int              errs;
		logic [XLEN-1:0] exp_val;
		logic [MEM_AW-1:0] ra;
		n    = nbytes(op_l);
		errs = 0;
		if (op_l[6:0] == OPC_STORE) begin
			exp_len = (n == 1) ? 2 : (n == 2) ? 3 : 5;
			for (int k = 0; k < n; k++) begin
				ra        = addr_l[MEM_AW-1:0] + MEM_AW'(k);
				ram_m[ra] = data_l[8*k +: 8];
			end
		end else begin
			exp_len = mhit_l ? 2 : (n == 1) ? 3 : (n == 2) ? 4 : 6;
			if (flag_l != mhit_l) begin
				$display("row %0d table expects a %s but the cache model says otherwise",
					id_l, flag_l ? "hit" : "miss");
				errs++;
			end
			exp_val = expect_load(addr_l, op_l[9:7]);
			if (wdata_o !== exp_val) begin
				$display("FAIL row %0d wdata_o got %h exp %h", id_l, wdata_o, exp_val);
				errs++;
			end
		end
		cache_update(addr_l, n);
		exp_len += frozen;   // frozen edges stretch the stall
		if (edges != exp_len) begin
			$display("FAIL row %0d stall_req_o length got %h exp %h", id_l, edges, exp_len);
			errs++;
		end
		if (errs == 0) begin
			$display("row %0d op %h addr %h ok, %0d edges", id_l, op_l, addr_l, edges);
			pass_cnt++;
		end else begin
			fail_cnt++;
		end
	endtask

	always @(posedge clk) begin
		if (active) begin
			edges++;
			if (stall_i) frozen++;
		end
		nm_prev    <= row_nm_i && !mem_op(opcode_i) && !stall_i;
		prev_wdata <= wdata_i;
		prev_wd    <= wd_i;
		prev_wreg  <= wreg_i;
	end

	always @(negedge clk) begin
		if (row_nm_i || mem_op(opcode_i)) seen_row = 1;
		if (!rst_i && !seen_row && (wreg_o !== 1'b0 || stall_req_o !== 1'b0)) begin
			$display("FAIL idle wreg_o %h stall_req_o %h exp 0 0", wreg_o, stall_req_o);
			fail_cnt++;
		end
		if (!active && mem_op(opcode_i) && stall_req_o) begin
			active = 1;
			edges  = 0;
			frozen = 0;
			op_l   = opcode_i;
			addr_l = addr_i;
			data_l = wdata_i;
			flag_l = exp_hit_i;
			id_l   = row_id_i;
			mhit_l = model_hit(addr_i, nbytes(opcode_i));
		end else if (active && !stall_req_o) begin
			finish_op();
			active = 0;
		end
		if (nm_prev) begin
			if (wdata_o !== prev_wdata || wd_o !== prev_wd || wreg_o !== prev_wreg) begin
				$display("FAIL row %0d wdata_o %h wd_o %h wreg_o %h exp %h %h %h", row_id_i,
					wdata_o, wd_o, wreg_o, prev_wdata, prev_wd, prev_wreg);
				fail_cnt++;
			end else if (stall_req_o !== 1'b0) begin
				$display("row %0d stall_req_o went high on a non-memory op", row_id_i);
				fail_cnt++;
			end else begin
				$display("row %0d non-memory ok", row_id_i);
				pass_cnt++;
			end
		end
	end

	always @(posedge run_done_i) begin
		$display("%0d rows passed, %0d failed", pass_cnt, fail_cnt);
	end

endmodule

/* rtl/mem_subsys_top.sv */
module mem_subsys_top import lsu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic [OP_W-1:0]       opcode_i,
	input  logic [ADDR_W-1:0]     addr_i,
	input  logic [XLEN-1:0]       wdata_i,
	input  logic [REG_ADDR_W-1:0] wd_i,
	input  logic                  wreg_i,
	input  logic                  stall_i,
	output logic [REG_ADDR_W-1:0] wd_o,
	output logic                  wreg_o,
	output logic [XLEN-1:0]       wdata_o,
	output logic                  stall_req_o
);

	dcache_if  dc_bus ();
	memctrl_if mc_bus ();

	// load/store sequencer
	lsu_stage u_lsu_stage (
		.clk         (clk),
		.rst_i       (rst_i),
		.opcode_i    (opcode_i),
		.addr_i      (addr_i),
		.wdata_i     (wdata_i),
		.wd_i        (wd_i),
		.wreg_i      (wreg_i),
		.stall_i     (stall_i),
		.wd_o        (wd_o),
		.wreg_o      (wreg_o),
		.wdata_o     (wdata_o),
		.stall_req_o (stall_req_o),
		.dc          (dc_bus.stage),
		.mc          (mc_bus.stage)
	);

	dcache u_dcache (
		.clk   (clk),
		.rst_i (rst_i),
		.dc    (dc_bus.cache)
	);

	// byte-wide backing RAM
	byte_mem_port u_byte_mem_port (
		.clk   (clk),
		.rst_i (rst_i),
		.mc    (mc_bus.port)
	);

endmodule

/* rtl/byte_mem_port.sv */
module byte_mem_port import lsu_pkg::*; (
	input logic     clk,
	input logic     rst_i,
	memctrl_if.port mc
);

	logic [7:0]        ram [2**MEM_AW];
	logic [MEM_AW-1:0] raddr_q;   // read address of the byte on rbyte

	// stores land on the edge
	always_ff @(posedge clk) begin
		if (mc.req == REQ_STORE) begin
			ram[mc.addr[MEM_AW-1:0]] <= mc.wbyte;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			raddr_q <= '0;
		end else if (mc.req == REQ_LOAD) begin
			raddr_q <= mc.addr[MEM_AW-1:0];
		end
	end

	assign mc.rbyte = ram[raddr_q];   // one cycle behind the request

	a_req_legal: assert property (@(posedge clk) disable iff (rst_i)
		mc.req != 2'b11)
		else $error("byte port request with reserved code");

endmodule

/* rtl/dcache.sv */
module dcache import lsu_pkg::*; (
	input logic     clk,
	input logic     rst_i,
	dcache_if.cache dc
);

	logic [TAG_W-1:0]            tag_mem [CACHE_LINES];
	data_word_u                  data_mem [CACHE_LINES];
	logic [CACHE_LINES-1:0][3:0] valid_q;   // one bit per byte lane

	logic [CACHE_IW-1:0] ridx, widx;
	logic [TAG_W-1:0]    rtag, wtag;
	logic [3:0]          rmask, wmask;
	logic                wtag_hit;
	data_word_u          wlanes;

	// lanes touched by an access of the given size
	function automatic logic [3:0] lane_mask(input logic [1:0] lo, input logic [1:0] size);
		case (size)
			SZ_BYTE: lane_mask = 4'b0001 << lo;
			SZ_HALF: lane_mask = lo[1] ? 4'b1100 : 4'b0011;
			default: lane_mask = 4'b1111;
		endcase
	endfunction

	assign ridx  = dc.raddr[CACHE_IW+1:2];
	assign rtag  = dc.raddr[ADDR_W-1:CACHE_IW+2];
	assign rmask = lane_mask(dc.raddr[1:0], dc.rsize);

	// hit needs the tag and every covered lane
	assign dc.hit   = (tag_mem[ridx] == rtag) && ((valid_q[ridx] & rmask) == rmask);
	assign dc.rdata = data_mem[ridx];

	assign widx     = dc.waddr[CACHE_IW+1:2];
	assign wtag     = dc.waddr[ADDR_W-1:CACHE_IW+2];
	assign wmask    = lane_mask(dc.waddr[1:0], dc.wsize);
	assign wtag_hit = (tag_mem[widx] == wtag);

	// spread the sized value over all lanes, wmask picks the live ones
	always_comb begin
		case (dc.wsize)
			SZ_BYTE: wlanes.b = {4{dc.wdata.b[0]}};
			SZ_HALF: wlanes.h = {2{dc.wdata.h[0]}};
			default: wlanes   = dc.wdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (dc.we) begin
			tag_mem[widx] <= wtag;
			for (int i = 0; i < 4; i++) begin
				if (wmask[i]) begin
					data_mem[widx].b[i] <= wlanes.b[i];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= '0;
		end else if (dc.we) begin
			// merge on tag match, else the line is taken over
			valid_q[widx] <= wtag_hit ? (valid_q[widx] | wmask) : wmask;
		end
	end

	a_wsize_legal: assert property (@(posedge clk) disable iff (rst_i)
		dc.we |-> (dc.wsize != 2'b11))
		else $error("cache write with reserved size code");

endmodule

/* rtl/lsu_stage.sv */
module lsu_stage import lsu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic [OP_W-1:0]       opcode_i,
	input  logic [ADDR_W-1:0]     addr_i,
	input  logic [XLEN-1:0]       wdata_i,
	input  logic [REG_ADDR_W-1:0] wd_i,
	input  logic                  wreg_i,
	input  logic                  stall_i,
	output logic [REG_ADDR_W-1:0] wd_o,
	output logic                  wreg_o,
	output logic [XLEN-1:0]       wdata_o,
	output logic                  stall_req_o,
	dcache_if.stage               dc,
	memctrl_if.stage              mc
);

	logic [2:0]        funct3;
	logic              is_load;
	logic              is_store;
	logic              is_mem;
	logic [1:0]        size_sel;
	logic              addr_ok;

	logic [5:0]        state_q, state_d;
	logic              done_q, done_d;
	logic [1:0]        req_q, req_d;
	logic              c_we_q, c_we_d;
	logic [ADDR_W-1:0] maddr_q, maddr_d;
	logic [ADDR_W-1:0] maddr_prev_q;
	logic [7:0]        wbyte_q, wbyte_d;
	logic [ADDR_W-1:0] op_addr_q, op_addr_d;
	logic [1:0]        size_q, size_d;
	logic [XLEN-1:0]   c_wdata_q, c_wdata_d;
	logic [XLEN-1:0]   wdata_d;
	logic [XLEN-1:0]   hit_raw;
	logic              finish;
	logic              fill;
	logic [XLEN-1:0]   fill_val;

	function automatic logic [XLEN-1:0] load_ext(input logic [XLEN-1:0] raw,
		input logic [2:0] f3);
		case (f3)
			F3_LB:   load_ext = {{24{raw[7]}}, raw[7:0]};
			F3_LBU:  load_ext = {24'b0, raw[7:0]};
			F3_LH:   load_ext = {{16{raw[15]}}, raw[15:0]};
			F3_LHU:  load_ext = {16'b0, raw[15:0]};
			default: load_ext = raw;
		endcase
	endfunction

	assign funct3   = opcode_i[9:7];
	assign is_load  = (opcode_i[6:0] == OPC_LOAD);
	assign is_store = (opcode_i[6:0] == OPC_STORE);
	assign is_mem   = is_load || is_store;

	always_comb begin
		if (is_load) begin
			case (funct3)
				F3_LH, F3_LHU: size_sel = SZ_HALF;
				F3_LW:         size_sel = SZ_WORD;
				default:       size_sel = SZ_BYTE;
			endcase
		end else begin
			case (funct3)
				F3_SH:   size_sel = SZ_HALF;
				F3_SW:   size_sel = SZ_WORD;
				default: size_sel = SZ_BYTE;
			endcase
		end
	end

	assign addr_ok = (size_sel == SZ_BYTE) || (size_sel == SZ_HALF && !addr_i[0]) ||
		(addr_i[1:0] == 2'b00);

	// lane pick on a hit
	always_comb begin
		case (size_q)
			SZ_BYTE: hit_raw = {24'b0, dc.rdata.b[op_addr_q[1:0]]};
			SZ_HALF: hit_raw = {16'b0, dc.rdata.h[op_addr_q[1]]};
			default: hit_raw = dc.rdata;
		endcase
	end

	always_comb begin
		state_d   = state_q;
		done_d    = done_q;
		req_d     = req_q;
		c_we_d    = 1'b0;
		maddr_d   = maddr_q;
		wbyte_d   = wbyte_q;
		op_addr_d = op_addr_q;
		size_d    = size_q;
		c_wdata_d = c_wdata_q;
		wdata_d   = wdata_o;
		finish    = 1'b0;
		fill      = 1'b0;
		fill_val  = '0;
		if (done_q) begin
			done_d = 1'b0;   // gap cycle between memory ops
		end else if (!is_mem) begin
			wdata_d = wdata_i;
			req_d   = REQ_NONE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					state_d   = ST_B0;
					maddr_d   = addr_i;
					op_addr_d = addr_i;
					size_d    = size_sel;
					if (is_load) begin
						req_d = REQ_LOAD;
					end else begin
						req_d     = REQ_STORE;
						wbyte_d   = wdata_i[7:0];
						c_we_d    = 1'b1;   // write-through straight away
						c_wdata_d = wdata_i;
					end
				end
				ST_B0: begin
					if (is_load && dc.hit) begin
						wdata_d = load_ext(hit_raw, funct3);
						finish  = 1'b1;
					end else if (is_store && size_q == SZ_BYTE) begin
						finish = 1'b1;
					end else begin
						state_d = ST_B1;
						if (size_q != SZ_BYTE) begin
							maddr_d = addr_i + 1;
							wbyte_d = wdata_i[15:8];
						end
					end
				end
				ST_B1: begin
					if (size_q == SZ_BYTE) begin   // LB/LBU miss
						fill     = 1'b1;
						fill_val = load_ext({24'b0, mc.rbyte}, funct3);
					end else if (is_store && size_q == SZ_HALF) begin
						finish = 1'b1;
					end else begin
						if (is_load) begin
							wdata_d[7:0] = mc.rbyte;
						end
						state_d = ST_B2;
						if (size_q == SZ_WORD) begin
							maddr_d = addr_i + 2;
							wbyte_d = wdata_i[23:16];
						end
					end
				end
				ST_B2: begin
					if (size_q == SZ_HALF) begin   // LH/LHU miss
						fill     = 1'b1;
						fill_val = load_ext({16'b0, mc.rbyte, wdata_o[7:0]}, funct3);
					end else begin
						if (is_load) begin
							wdata_d[15:8] = mc.rbyte;
						end
						maddr_d = addr_i + 3;
						wbyte_d = wdata_i[31:24];
						state_d = ST_B3;
					end
				end
				ST_B3: begin
					if (is_store) begin
						finish = 1'b1;
					end else begin
						wdata_d[23:16] = mc.rbyte;
						state_d        = ST_FIN;
					end
				end
				ST_FIN: begin
					fill     = 1'b1;
					fill_val = {mc.rbyte, wdata_o[23:0]};
				end
				default: state_d = ST_IDLE;
			endcase
		end
		// a miss fill also finishes the op
		if (fill) begin
			wdata_d   = fill_val;
			c_we_d    = 1'b1;
			c_wdata_d = fill_val;
			finish    = 1'b1;
		end
		if (finish) begin
			req_d   = REQ_NONE;
			done_d  = 1'b1;
			state_d = ST_IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= ST_IDLE;
			done_q  <= 1'b0;
			req_q   <= REQ_NONE;
			c_we_q  <= 1'b0;
			wreg_o  <= 1'b0;
		end else if (!stall_i) begin
			state_q <= state_d;
			done_q  <= done_d;
			req_q   <= req_d;
			c_we_q  <= c_we_d;
			wreg_o  <= wreg_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			maddr_q      <= maddr_d;
			maddr_prev_q <= maddr_q;
			wbyte_q      <= wbyte_d;
			op_addr_q    <= op_addr_d;
			size_q       <= size_d;
			c_wdata_q    <= c_wdata_d;
			wdata_o      <= wdata_d;
			wd_o         <= wd_i;
		end
	end

	assign stall_req_o = is_mem && !done_q;

	assign dc.raddr = op_addr_q;
	assign dc.rsize = size_q;
	assign dc.we    = c_we_q;
	assign dc.waddr = op_addr_q;
	assign dc.wsize = size_q;
	assign dc.wdata = c_wdata_q;

	// while frozen a load keeps pointing at the byte already in flight,
	// so rbyte still holds it when the sequence resumes
	assign mc.addr  = (stall_i && req_q == REQ_LOAD) ? maddr_prev_q : maddr_q;
	assign mc.req   = req_q;
	assign mc.wbyte = wbyte_q;

	a_aligned: assert property (@(posedge clk) disable iff (rst_i)
		(is_mem && !done_q) |-> addr_ok)
		else $error("misaligned memory access at %h", addr_i);

	a_no_store_req_on_load: assert property (@(posedge clk) disable iff (rst_i)
		is_load |-> (mc.req != REQ_STORE))
		else $error("store request on the byte port during a load");

endmodule

/* rtl/memctrl_if.sv */
interface memctrl_if import lsu_pkg::*; ();

	logic [1:0]        req;     // REQ_NONE / REQ_LOAD / REQ_STORE
	logic [ADDR_W-1:0] addr;
	logic [7:0]        wbyte;
	logic [7:0]        rbyte;   // byte at the address sampled one edge earlier

	modport stage (
		output req, addr, wbyte,
		input  rbyte
	);

	modport port (
		input  req, addr, wbyte,
		output rbyte
	);

endinterface

/* rtl/dcache_if.sv */
interface dcache_if import lsu_pkg::*; ();

	// lookup side, answered combinationally
	logic [ADDR_W-1:0] raddr;
	logic [1:0]        rsize;
	logic              hit;
	data_word_u        rdata;   // whole line word

	// write side, one-cycle pulse on we
	logic              we;
	logic [ADDR_W-1:0] waddr;
	logic [1:0]        wsize;
	data_word_u        wdata;   // low bits carry the sized value

	modport stage (
		output raddr, rsize, we, waddr, wsize, wdata,
		input  hit, rdata
	);

	modport cache (
		input  raddr, rsize, we, waddr, wsize, wdata,
		output hit, rdata
	);

endinterface

/* rtl/lsu_pkg.sv */
package lsu_pkg;

	// widths
	localparam int XLEN       = 32;
	localparam int ADDR_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int OP_W       = 10;   // funct3 in [9:7], opcode in [6:0]
	localparam int MEM_AW     = 10;   // 1 KiB byte RAM
	localparam int CACHE_LINES = 32;
	localparam int CACHE_IW   = 5;
	localparam int TAG_W      = ADDR_W - CACHE_IW - 2;

	// major opcodes
	localparam logic [6:0] OPC_LOAD  = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;

	// funct3 for loads
	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;
	// funct3 for stores
	localparam logic [2:0] F3_SB  = 3'b000;
	localparam logic [2:0] F3_SH  = 3'b001;
	localparam logic [2:0] F3_SW  = 3'b010;

	// access size on the cache bus, 2'b11 is unused
	localparam logic [1:0] SZ_BYTE = 2'b00;
	localparam logic [1:0] SZ_HALF = 2'b01;
	localparam logic [1:0] SZ_WORD = 2'b10;

	// byte port request codes
	localparam logic [1:0] REQ_NONE  = 2'b00;
	localparam logic [1:0] REQ_LOAD  = 2'b01;
	localparam logic [1:0] REQ_STORE = 2'b10;

	// one-hot states of the load/store sequencer
	localparam logic [5:0] ST_IDLE = 6'b000001;
	localparam logic [5:0] ST_B0   = 6'b000010;
	localparam logic [5:0] ST_B1   = 6'b000100;
	localparam logic [5:0] ST_B2   = 6'b001000;
	localparam logic [5:0] ST_B3   = 6'b010000;
	localparam logic [5:0] ST_FIN  = 6'b100000;

	// one cache word, seen as bytes or as halfwords
	typedef union packed {
		logic [3:0][7:0]  b;
		logic [1:0][15:0] h;
	} data_word_u;

endpackage
